// ==== compile.f ====
logic/gb_core_pkg.sv
logic/alu.sv
logic/gb_decoder.sv
logic/gb_regfile.sv
logic/gb_exec_core.sv
tb/tb_clock_gen.sv
tb/gb_exec_core_tb.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [7:0]           alu_a,
    input  logic [7:0]           alu_b,
    input  logic [2:0]           alu_bit_index,
    input  gb_core_pkg::flags_t  alu_flags_in,
    input  gb_core_pkg::alu_op_t alu_op,
    output logic [7:0]           alu_result,
    output gb_core_pkg::flags_t  alu_flags_out
);
    import gb_core_pkg::*;

    logic       carry_in;
    logic [4:0] nib;
    logic [8:0] full;
    logic [8:0] adj_lo;
    logic [8:0] adj_hi;

    always_comb begin
        carry_in      = 1'b0;
        nib           = '0;
        full          = '0;
        adj_lo        = '0;
        adj_hi        = '0;
        alu_result    = alu_b;
        alu_flags_out = alu_flags_in;
        case (alu_op)
            //////////////////////////////
            // Arithmetic
            //////////////////////////////
            ALU_ADD, ALU_ADC: begin
                carry_in      = (alu_op == ALU_ADC) && alu_flags_in.c;
                nib           = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]} + {4'b0, carry_in};
                full          = {1'b0, alu_a} + {1'b0, alu_b} + {8'b0, carry_in};
                alu_result    = full[7:0];
                alu_flags_out = '{z: (full[7:0] == 8'h00), n: 1'b0, h: nib[4], c: full[8]};
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                // Bit 4 and bit 8 come out set on a borrow
                carry_in      = (alu_op == ALU_SBC) && alu_flags_in.c;
                nib           = {1'b0, alu_a[3:0]} - {1'b0, alu_b[3:0]} - {4'b0, carry_in};
                full          = {1'b0, alu_a} - {1'b0, alu_b} - {8'b0, carry_in};
                alu_result    = (alu_op == ALU_CP) ? alu_b : full[7:0];
                alu_flags_out = '{z: (full[7:0] == 8'h00), n: 1'b1, h: nib[4], c: full[8]};
            end
            ALU_AND: begin
                alu_result    = alu_a & alu_b;
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
            end
            ALU_XOR: begin
                alu_result    = alu_a ^ alu_b;
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
            end
            ALU_OR: begin
                alu_result    = alu_a | alu_b;
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
            end
            ALU_DAA: begin
                if (!alu_flags_in.n) begin
                    adj_lo = (alu_flags_in.h || alu_a[3:0] > 4'h9) ?
                             {1'b0, alu_a} + 9'h006 : {1'b0, alu_a};
                    adj_hi = (alu_flags_in.c || adj_lo > 9'h09f) ? adj_lo + 9'h060 : adj_lo;
                end else begin
                    adj_lo = alu_flags_in.h ? {1'b0, alu_a - 8'h06} : {1'b0, alu_a};
                    adj_hi = alu_flags_in.c ? adj_lo - 9'h060 : adj_lo;
                end
                alu_result    = adj_hi[7:0];
                alu_flags_out = '{z: (adj_hi[7:0] == 8'h00), n: alu_flags_in.n, h: 1'b0,
                                  c: adj_hi[8] | alu_flags_in.c};
            end
            ALU_CPL: begin
                alu_result    = ~alu_a;
                alu_flags_out = '{z: alu_flags_in.z, n: 1'b1, h: 1'b1, c: alu_flags_in.c};
            end
            ALU_SCF: begin
                alu_flags_out = '{z: alu_flags_in.z, n: 1'b0, h: 1'b0, c: 1'b1};
            end
            ALU_CCF: begin
                alu_flags_out = '{z: alu_flags_in.z, n: 1'b0, h: 1'b0, c: ~alu_flags_in.c};
            end
            //////////////////////////////
            // CB rotates and shifts
            //////////////////////////////
            ALU_RLC: begin
                alu_result    = {alu_a[6:0], alu_a[7]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[7]};
            end
            ALU_RRC: begin
                alu_result    = {alu_a[0], alu_a[7:1]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[0]};
            end
            ALU_RL: begin
                alu_result    = {alu_a[6:0], alu_flags_in.c};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[7]};
            end
            ALU_RR: begin
                alu_result    = {alu_flags_in.c, alu_a[7:1]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[0]};
            end
            ALU_SLA: begin
                alu_result    = {alu_a[6:0], 1'b0};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[7]};
            end
            ALU_SRA: begin
                alu_result    = {alu_a[7], alu_a[7:1]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[0]};
            end
            ALU_SRL: begin
                alu_result    = {1'b0, alu_a[7:1]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: alu_a[0]};
            end
            ALU_SWAP: begin
                alu_result    = {alu_a[3:0], alu_a[7:4]};
                alu_flags_out = '{z: (alu_result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
            end
            //////////////////////////////
            // Single bit ops
            //////////////////////////////
            ALU_BIT: begin
                alu_flags_out = '{z: ~alu_a[alu_bit_index], n: 1'b0, h: 1'b1,
                                  c: alu_flags_in.c};
            end
            ALU_SET: begin
                alu_result                = alu_a;
                alu_result[alu_bit_index] = 1'b1;
            end
            ALU_RES: begin
                alu_result                = alu_a;
                alu_result[alu_bit_index] = 1'b0;
            end
            // ALU_PASS and the unused codes keep the defaults
            default: begin
                alu_result    = alu_b;
                alu_flags_out = alu_flags_in;
            end
        endcase
    end

endmodule

// ==== logic/gb_core_pkg.sv ====
package gb_core_pkg;

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_ADC  = 5'b00001,
        ALU_SUB  = 5'b00010,
        ALU_SBC  = 5'b00011,
        ALU_AND  = 5'b00100,
        ALU_XOR  = 5'b00101,
        ALU_OR   = 5'b00110,
        ALU_CP   = 5'b00111,
        ALU_RLC  = 5'b01000,
        ALU_RRC  = 5'b01001,
        ALU_RL   = 5'b01010,
        ALU_RR   = 5'b01011,
        ALU_SLA  = 5'b01100,
        ALU_SRA  = 5'b01101,
        ALU_SWAP = 5'b01110,
        ALU_SRL  = 5'b01111,
        ALU_DAA  = 5'b10100,
        ALU_CPL  = 5'b10101,
        ALU_SCF  = 5'b10110,
        ALU_CCF  = 5'b10111,
        // Operand B straight through, flags kept
        ALU_PASS = 5'b11000,
        ALU_BIT  = 5'b11101,
        ALU_RES  = 5'b11110,
        ALU_SET  = 5'b11111
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    // B, C, D, E, H, L, (HL), A
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_HL_IND = 3'd6;
    localparam reg_idx_t REG_A      = 3'd7;

    localparam logic [7:0] CB_PREFIX = 8'hCB;

    typedef enum logic {
        B_SRC_REG,
        B_SRC_IMM
    } b_src_t;

    typedef struct packed {
        alu_op_t    op;
        reg_idx_t   a_sel;
        reg_idx_t   b_sel;
        b_src_t     b_src;
        logic [7:0] imm;
        logic [2:0] bit_index;
        reg_idx_t   dest;
        logic       wr_reg;
        logic       wr_flags;
    } alu_req_t;

    typedef struct packed {
        reg_idx_t   dest;
        logic       wr_reg;
        logic [7:0] value;
        flags_t     flags;
        logic       wr_flags;
    } wb_t;

    typedef enum logic [1:0] {
        DEC_OPCODE,
        DEC_CB,
        DEC_IMM
    } dec_state_t;

endpackage

// ==== logic/gb_decoder.sv ====
`timescale 1ns/1ps

module gb_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  code_valid,
    input  logic [7:0]            code,
    output logic                  req_valid,
    output gb_core_pkg::alu_req_t req
);
    import gb_core_pkg::*;

    dec_state_t state;
    dec_state_t state_next;
    logic [7:0] pending;
    logic [7:0] op_byte;
    logic       imm_form;
    logic       issue;
    alu_req_t   req_next;

    // LD r,n and the ALU immediate forms both end in 3'b110
    assign imm_form = (code[2:0] == 3'b110) && (code[7:6] == 2'b00 || code[7:6] == 2'b11);

    always_comb begin
        state_next = DEC_OPCODE;
        if (state == DEC_OPCODE) begin
            if (code == CB_PREFIX) begin
                state_next = DEC_CB;
            end else if (imm_form) begin
                state_next = DEC_IMM;
            end
        end
    end

    assign issue = code_valid && (state_next == DEC_OPCODE);

    //////////////////////////////
    // Request decode
    //////////////////////////////
    always_comb begin
        op_byte            = (state == DEC_IMM) ? pending : code;
        req_next           = '0;
        req_next.op        = ALU_PASS;
        req_next.a_sel     = REG_A;
        req_next.b_sel     = op_byte[2:0];
        req_next.b_src     = B_SRC_REG;
        req_next.imm       = code;
        req_next.bit_index = op_byte[5:3];
        req_next.dest      = REG_A;
        if (state == DEC_CB) begin
            req_next.a_sel = op_byte[2:0];
            req_next.dest  = op_byte[2:0];
            case (op_byte[7:6])
                2'b00:   req_next.op = alu_op_t'({2'b01, op_byte[5:3]});
                2'b01:   req_next.op = ALU_BIT;
                2'b10:   req_next.op = ALU_RES;
                default: req_next.op = ALU_SET;
            endcase
            if (op_byte[2:0] != REG_HL_IND) begin
                req_next.wr_reg   = (op_byte[7:6] != 2'b01);
                req_next.wr_flags = (op_byte[7:6] <= 2'b01);
            end
        end else if (op_byte[7:6] == 2'b10) begin
            req_next.op = alu_op_t'({2'b00, op_byte[5:3]});
            if (op_byte[2:0] != REG_HL_IND) begin
                req_next.wr_reg   = (op_byte[5:3] != 3'd7);
                req_next.wr_flags = 1'b1;
            end
        end else if (op_byte[2:0] == 3'b110 && op_byte[7:6] == 2'b11) begin
            req_next.op       = alu_op_t'({2'b00, op_byte[5:3]});
            req_next.b_src    = B_SRC_IMM;
            req_next.wr_reg   = (op_byte[5:3] != 3'd7);
            req_next.wr_flags = 1'b1;
        end else if (op_byte[2:0] == 3'b110 && op_byte[7:6] == 2'b00) begin
            // LD r,n
            req_next.b_src  = B_SRC_IMM;
            req_next.dest   = op_byte[5:3];
            req_next.wr_reg = (op_byte[5:3] != REG_HL_IND);
        end else if (op_byte[7:6] == 2'b00 && op_byte[2:0] == 3'b111 && op_byte[5]) begin
            // 0x27 DAA, 0x2F CPL, 0x37 SCF, 0x3F CCF
            req_next.op       = alu_op_t'({3'b101, op_byte[4:3]});
            req_next.b_sel    = REG_A;
            req_next.wr_reg   = !op_byte[4];
            req_next.wr_flags = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DEC_OPCODE;
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue;
            if (code_valid) begin
                state <= state_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid && state == DEC_OPCODE) begin
            pending <= code;
        end
        if (issue) begin
            req <= req_next;
        end
    end

endmodule

// ==== logic/gb_exec_core.sv ====
`timescale 1ns/1ps

module gb_exec_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                code_valid,
    input  logic [7:0]          code,
    output logic                retire,
    output gb_core_pkg::wb_t    retire_wb,
    output logic [7:0]          reg_a,
    output gb_core_pkg::flags_t flags
);
    import gb_core_pkg::*;

    logic       req_valid;
    alu_req_t   req;
    logic [7:0] rd_a;
    logic [7:0] rd_b;
    logic [7:0] alu_result;
    flags_t     alu_flags;

    gb_decoder gb_decoder_inst (
        .clk        (clk),
        .rst        (rst),
        .code_valid (code_valid),
        .code       (code),
        .req_valid  (req_valid),
        .req        (req)
    );

    // Operands and current F feed the ALU in the req_valid cycle
    gb_regfile gb_regfile_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .flags      (flags),
        .reg_a      (reg_a),
        .retire     (retire),
        .retire_wb  (retire_wb)
    );

    alu alu_inst (
        .alu_a         (rd_a),
        .alu_b         (rd_b),
        .alu_bit_index (req.bit_index),
        .alu_flags_in  (flags),
        .alu_op        (req.op),
        .alu_result    (alu_result),
        .alu_flags_out (alu_flags)
    );

endmodule

// ==== logic/gb_regfile.sv ====
`timescale 1ns/1ps

module gb_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  gb_core_pkg::alu_req_t req,
    input  logic [7:0]            alu_result,
    input  gb_core_pkg::flags_t   alu_flags,
    output logic [7:0]            rd_a,
    output logic [7:0]            rd_b,
    output gb_core_pkg::flags_t   flags,
    output logic [7:0]            reg_a,
    output logic                  retire,
    output gb_core_pkg::wb_t      retire_wb
);
    import gb_core_pkg::*;

    // B through L, accumulator and F held apart
    logic [7:0] gpr [0:5];
    logic [7:0] acc;
    flags_t     f;

    function automatic logic [7:0] read_reg(input reg_idx_t sel);
        if (sel == REG_A) begin
            return acc;
        end
        if (sel == REG_HL_IND) begin
            return 8'h00;
        end
        return gpr[sel];
    endfunction

    assign rd_a  = read_reg(req.a_sel);
    assign rd_b  = (req.b_src == B_SRC_IMM) ? req.imm : read_reg(req.b_sel);
    assign flags = f;
    assign reg_a = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 6; i++) begin
                gpr[i] <= 8'h00;
            end
            acc    <= 8'h00;
            f      <= '0;
            retire <= 1'b0;
        end else begin
            retire <= req_valid;
            if (req_valid && req.wr_reg) begin
                if (req.dest == REG_A) begin
                    acc <= alu_result;
                end else if (req.dest != REG_HL_IND) begin
                    gpr[req.dest] <= alu_result;
                end
            end
            if (req_valid && req.wr_flags) begin
                f <= alu_flags;
            end
        end
    end

    // Commit record
    always_ff @(posedge clk) begin
        if (req_valid) begin
            retire_wb <= '{dest: req.dest, wr_reg: req.wr_reg, value: alu_result,
                           flags: alu_flags, wr_flags: req.wr_flags};
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module gb_exec_core_tb -f compile.f -o sim_gb_exec_core

out=$(./obj_dir/sim_gb_exec_core)
echo "$out"

echo "$out" | grep -qx "all tests passed"

// ==== tb/gb_exec_core_tb.sv ====
`timescale 1ns/1ps

module gb_exec_core_tb;
    import gb_core_pkg::*;

    logic       clk;
    logic       rst;
    logic       code_valid;
    logic [7:0] code;
    logic       retire;
    wb_t        retire_wb;
    logic [7:0] reg_a;
    flags_t     flags;

    // Model copy of the register file and F
    logic [7:0] regs_m [0:7];
    flags_t     f_m;
    wb_t        exp_q [$];
    int         cyc_q [$];
    int         cyc = 0;
    int         errors = 0;
    int         err_start = 0;
    int         test_num = 0;
    int         n_ok = 0;
    int         n_bad = 0;
    int         max_gap = 2;

    tb_clock_gen tb_clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    gb_exec_core gb_exec_core_inst (
        .clk        (clk),
        .rst        (rst),
        .code_valid (code_valid),
        .code       (code),
        .retire     (retire),
        .retire_wb  (retire_wb),
        .reg_a      (reg_a),
        .flags      (flags)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic wb_t model_exec(input logic [7:0] b0, input logic [7:0] b1);
        wb_t        w;
        flags_t     nf;
        logic [7:0] a;
        logic [7:0] v;
        logic [7:0] r;
        logic [7:0] x;
        logic [8:0] s;
        logic       cin;
        w      = '0;
        w.dest = REG_A;
        nf     = f_m;
        r      = 8'h00;
        if (b0 == CB_PREFIX) begin
            w.dest = b1[2:0];
            v      = regs_m[b1[2:0]];
            r      = v;
            case (b1[7:6])
                2'b00: begin
                    case (b1[5:3])
                        3'd0:    r = {v[6:0], v[7]};
                        3'd1:    r = {v[0], v[7:1]};
                        3'd2:    r = {v[6:0], f_m.c};
                        3'd3:    r = {f_m.c, v[7:1]};
                        3'd4:    r = {v[6:0], 1'b0};
                        3'd5:    r = {v[7], v[7:1]};
                        3'd6:    r = {v[3:0], v[7:4]};
                        default: r = {1'b0, v[7:1]};
                    endcase
                    // Left moves shift out bit 7, right moves bit 0, SWAP none
                    nf = '{z: (r == 8'h00), n: 1'b0, h: 1'b0,
                           c: (b1[5:3] == 3'd6) ? 1'b0 : (b1[3] ? v[0] : v[7])};
                    w.wr_reg   = 1'b1;
                    w.wr_flags = 1'b1;
                end
                2'b01: begin
                    nf         = '{z: ~v[b1[5:3]], n: 1'b0, h: 1'b1, c: f_m.c};
                    w.wr_flags = 1'b1;
                end
                2'b10: begin
                    r[b1[5:3]] = 1'b0;
                    w.wr_reg   = 1'b1;
                end
                default: begin
                    r[b1[5:3]] = 1'b1;
                    w.wr_reg   = 1'b1;
                end
            endcase
            if (b1[2:0] == REG_HL_IND) begin
                w.wr_reg   = 1'b0;
                w.wr_flags = 1'b0;
            end
        end else if (b0[7:6] == 2'b10 || (b0[7:6] == 2'b11 && b0[2:0] == 3'b110)) begin
            a   = regs_m[REG_A];
            v   = b0[6] ? b1 : regs_m[b0[2:0]];
            cin = f_m.c && (b0[5:3] == 3'd1 || b0[5:3] == 3'd3);
            case (b0[5:3])
                3'd0, 3'd1: begin
                    s  = {1'b0, a} + {1'b0, v} + {8'h00, cin};
                    r  = s[7:0];
                    x  = a ^ v ^ r;
                    nf = '{z: (r == 8'h00), n: 1'b0, h: x[4], c: s[8]};
                end
                3'd2, 3'd3, 3'd7: begin
                    r  = a - v - {7'h00, cin};
                    x  = a ^ v ^ r;
                    nf = '{z: (r == 8'h00), n: 1'b1, h: x[4],
                           c: (({1'b0, v} + {8'h00, cin}) > {1'b0, a})};
                end
                3'd4: begin
                    r  = a & v;
                    nf = '{z: (r == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
                end
                3'd5: begin
                    r  = a ^ v;
                    nf = '{z: (r == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
                end
                default: begin
                    r  = a | v;
                    nf = '{z: (r == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
                end
            endcase
            w.wr_reg   = (b0[5:3] != 3'd7);
            w.wr_flags = 1'b1;
            if (!b0[6] && b0[2:0] == REG_HL_IND) begin
                w.wr_reg   = 1'b0;
                w.wr_flags = 1'b0;
            end
        end else if (b0[7:6] == 2'b00 && b0[2:0] == 3'b110) begin
            r        = b1;
            w.dest   = b0[5:3];
            w.wr_reg = (b0[5:3] != REG_HL_IND);
        end else begin
            case (b0)
                8'h27: begin
                    s = {1'b0, regs_m[REG_A]};
                    if (!f_m.n) begin
                        if (f_m.c || s > 9'h099) begin
                            s    = s + 9'h060;
                            nf.c = 1'b1;
                        end
                        if (f_m.h || s[3:0] > 4'h9) begin
                            s = s + 9'h006;
                        end
                    end else begin
                        if (f_m.c) begin
                            s = s - 9'h060;
                        end
                        if (f_m.h) begin
                            s = s - 9'h006;
                        end
                    end
                    r          = s[7:0];
                    nf.z       = (r == 8'h00);
                    nf.h       = 1'b0;
                    w.wr_reg   = 1'b1;
                    w.wr_flags = 1'b1;
                end
                8'h2F: begin
                    r          = ~regs_m[REG_A];
                    nf.n       = 1'b1;
                    nf.h       = 1'b1;
                    w.wr_reg   = 1'b1;
                    w.wr_flags = 1'b1;
                end
                8'h37, 8'h3F: begin
                    nf.n       = 1'b0;
                    nf.h       = 1'b0;
                    nf.c       = b0[3] ? ~f_m.c : 1'b1;
                    w.wr_flags = 1'b1;
                end
                default: begin
                end
            endcase
        end
        if (w.wr_reg) begin
            regs_m[w.dest] = r;
        end
        if (w.wr_flags) begin
            f_m = nf;
        end
        w.value = r;
        w.flags = f_m;
        return w;
    endfunction

    function automatic logic [7:0] to_bcd(input int n);
        return 8'((n / 10) * 16 + n % 10);
    endfunction

    function automatic reg_idx_t pick_reg();
        reg_idx_t r;
        r = reg_idx_t'($urandom % 7);
        return (r == REG_HL_IND) ? REG_A : r;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            $display("FAILED flags: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if ({got.wr_reg, got.wr_flags} !== {exp.wr_reg, exp.wr_flags}) begin
            $display("FAILED retire_wb.wr_reg/wr_flags: got %h expected %h",
                     {got.wr_reg, got.wr_flags}, {exp.wr_reg, exp.wr_flags});
            errors++;
        end
        if (exp.wr_reg && got.dest !== exp.dest) begin
            $display("FAILED retire_wb.dest: got %h expected %h", got.dest, exp.dest);
            errors++;
        end
        if (exp.wr_reg && got.value !== exp.value) begin
            $display("FAILED retire_wb.value: got %h expected %h", got.value, exp.value);
            errors++;
        end
        if (exp.wr_flags && got.flags !== exp.flags) begin
            $display("FAILED retire_wb.flags: got %h expected %h", got.flags, exp.flags);
            errors++;
        end
    endtask

    always @(negedge clk) begin : compare
        wb_t exp_wb;
        int  exp_cyc;
        if (rst === 1'b0 && retire === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("retire came with no instruction pending");
                errors++;
            end else begin
                exp_wb  = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                check_wb(retire_wb, exp_wb);
                check_flags(flags, exp_wb.flags);
                if (cyc != exp_cyc) begin
                    $display("retire came in cycle %0d instead of cycle %0d", cyc, exp_cyc);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic drive_byte(input logic [7:0] b);
        int gap;
        gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
            code_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        code_valid = 1'b1;
        code       = b;
    endtask

    task automatic send_instr(input logic [7:0] b0, input logic [7:0] b1);
        drive_byte(b0);
        if (b0 == CB_PREFIX || (b0[2:0] == 3'b110 && b0[7] == b0[6])) begin
            drive_byte(b1);
        end
        exp_q.push_back(model_exec(b0, b1));
        // Sampled next edge, req_valid one edge later, retire seen after the next
        cyc_q.push_back(cyc + 2);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        code_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int i;
        i = 0;
        while (exp_q.size() != 0 && i < 20) begin
            @(posedge clk);
            i++;
        end
        if (exp_q.size() != 0) begin
            $display("retire never came for %0d pending instructions", exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic run_alu_ops(input logic [7:0] mask, input int count);
        logic [2:0] o;
        for (int n = 0; n < count; n++) begin
            do begin
                o = 3'($urandom % 8);
            end while (!mask[o]);
            send_instr(8'h3E, 8'($urandom));
            if ($urandom % 2 == 0) begin
                send_instr({2'b11, o, 3'b110}, 8'($urandom));
            end else begin
                send_instr({2'b10, o, pick_reg()}, 8'h00);
            end
        end
    endtask

    task automatic finish_test(input string name);
        go_idle();
        wait_drain();
        test_num++;
        if (errors == err_start) begin
            n_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            n_bad++;
            $display("test %0d %s: %0d errors", test_num, name, errors - err_start);
        end
        err_start = errors;
    endtask

    initial begin
        int unsigned seed_val;
        int          i;
        int          xd;
        int          yd;
        reg_idx_t    r;
        seed_val   = $urandom(32'h804);
        code_valid = 1'b0;
        code       = 8'h00;
        f_m        = '0;
        for (i = 0; i < 8; i++) begin
            regs_m[i] = 8'h00;
        end

        i = 0;
        while (rst !== 1'b0 && i < 20) begin
            @(posedge clk);
            #1;
            i++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end
        check_byte("reg_a", reg_a, 8'h00);
        check_flags(flags, '0);
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (retire !== 1'b0) begin
                $display("retire went high with no instruction sent");
                errors++;
            end
        end
        for (i = 0; i < 8; i++) begin
            if (i != REG_HL_IND) begin
                send_instr({2'b00, 3'(i), 3'b110}, 8'($urandom));
            end
        end
        finish_test("reset and loads");

        run_alu_ops(8'b0000_0011, 40);
        finish_test("addition");

        run_alu_ops(8'b1000_1100, 40);
        finish_test("subtraction");

        run_alu_ops(8'b0111_0000, 30);
        for (i = 0; i < 12; i++) begin
            xd = int'($urandom % 100);
            yd = int'($urandom % 100);
            send_instr(8'h3E, to_bcd(xd));
            send_instr(8'h06, to_bcd(yd));
            send_instr(i[0] ? 8'h90 : 8'h80, 8'h00);
            send_instr(8'h27, 8'h00);
            go_idle();
            wait_drain();
            check_byte("reg_a", reg_a, to_bcd(i[0] ? (xd + 100 - yd) % 100 : (xd + yd) % 100));
        end
        for (i = 0; i < 12; i++) begin
            if (i % 4 == 0) begin
                send_instr(8'h3E, 8'($urandom));
            end
            send_instr(8'h2F + {2'b00, 3'($urandom % 3), 3'b000}, 8'h00);
        end
        finish_test("logic and adjust");

        for (i = 0; i < 40; i++) begin
            r = pick_reg();
            if (i % 8 == 0) begin
                send_instr({2'b00, r, 3'b110}, 8'($urandom));
            end
            send_instr(CB_PREFIX, {2'b00, 3'($urandom % 8), r});
        end
        finish_test("cb rotates and shifts");

        for (i = 0; i < 8; i++) begin
            r = pick_reg();
            send_instr(CB_PREFIX, {2'b01, 3'(i), r});
            send_instr(CB_PREFIX, {2'b11, 3'(i), r});
            send_instr(CB_PREFIX, {2'b01, 3'(i), r});
            send_instr(CB_PREFIX, {2'b10, 3'(i), r});
            send_instr(CB_PREFIX, {2'b01, 3'(i), r});
        end
        // Back to back, (HL) forms mixed in
        max_gap = 0;
        send_instr(8'h3E, 8'h5A);
        send_instr(8'hC6, 8'hA7);
        send_instr(CB_PREFIX, 8'h00);
        send_instr(8'h90, 8'h00);
        send_instr(8'h86, 8'h00);
        send_instr(CB_PREFIX, 8'h06);
        send_instr(8'h36, 8'h11);
        send_instr(CB_PREFIX, 8'hC6);
        send_instr(8'hBE, 8'h00);
        send_instr(8'h2F, 8'h00);
        send_instr(8'h37, 8'h00);
        finish_test("bits and sequencing");

        $display("%0d tests ok, %0d tests with errors", n_ok, n_bad);
        if (n_bad == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
